/* src/music_pkg.sv */
package music_pkg;

    typedef enum logic [1:0] {
        VOICE_CELLO    = 2'd0,
        VOICE_VIOLIN_1 = 2'd1,
        VOICE_VIOLIN_2 = 2'd2,
        VOICE_VIOLIN_3 = 2'd3
    } voice_e;

    typedef struct packed {
        logic [1:0] dur;
        logic [4:0] pitch;   // 0 is a rest
    } note_code_t;

    typedef logic [5:0] score_idx_t;

    localparam int NUM_VOICES   = 4;
    localparam int NUM_VIOLINS  = 3;
    localparam int COUNT_W      = 24;
    localparam int LOW_COUNT_W  = 10;
    localparam int STEP_W       = 14;
    localparam int BEAT_LSB     = 14;
    localparam int BEAT_W       = 3;
    localparam int CROTCHET_LSB = 17;
    localparam int SCORE_LEN    = 64;

    // Canon offsets and loop points
    localparam score_idx_t VIOLIN_START   = 6'd40;
    localparam score_idx_t VIOLIN_STAGGER = 6'd8;
    localparam score_idx_t FAST_STEP      = 6'd4;
    localparam score_idx_t LOOP_END       = 6'd60;
    localparam score_idx_t LOOP_TARGET    = 6'd8;
    localparam score_idx_t LOOP_SPACING   = 6'd4;
    localparam score_idx_t CELLO_REST_IDX = 6'd56;

    // Entry value is dur * 32 + pitch
    localparam note_code_t VIOLIN_SCORE [SCORE_LEN] = '{
        7'd44,  7'd43,  7'd42,  7'd41,  7'd40,  7'd39,  7'd40,  7'd41,
        7'd108, 7'd106, 7'd107, 7'd105, 7'd104, 7'd103, 7'd104, 7'd105,
        7'd12,  7'd13,  7'd14,  7'd12,  7'd10,  7'd11,  7'd12,  7'd10,
        7'd46,  7'd44,  7'd45,  7'd43,  7'd41,  7'd42,  7'd44,  7'd40,
        7'd9,   7'd10,  7'd11,  7'd12,  7'd13,  7'd14,  7'd15,  7'd16,
        7'd47,  7'd46,  7'd44,  7'd45,  7'd43,  7'd42,  7'd41,  7'd40,
        7'd10,  7'd0,   7'd10,  7'd0,   7'd9,   7'd0,   7'd9,   7'd0,
        7'd108, 7'd104, 7'd103, 7'd105, 7'd76,  7'd72,  7'd32,  7'd96
    };

endpackage

/* src/audio_pkg.sv */
package audio_pkg;

    // Half-period in units of four clocks, 0 is silent
    typedef logic [10:0] divider_t;

    typedef logic [7:0] sample_t;

    typedef struct packed {
        music_pkg::voice_e voice;
        divider_t          divider;
    } voice_tick_t;

    // Level each voice adds while its square wave is high
    localparam sample_t CELLO_WEIGHT  = 8'd64;
    localparam sample_t VIOLIN_WEIGHT = 8'd48;

    localparam int FRAME_W = 8;   // 256 cycle PWM frame

endpackage

/* src/beat_counter.sv */
`timescale 1ns/1ps

module beat_counter (
    input  logic                              clk,
    input  logic                              rst_n,
    output logic [music_pkg::COUNT_W-1:0]     count,
    output music_pkg::voice_e                 slot,
    output logic                              step_strobe
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= music_pkg::COUNT_W'(1);
        end else begin
            count <= count + 1'b1;
        end
    end

    // One voice slot per clock
    assign slot = music_pkg::voice_e'(count[1:0]);

    // Low step bits equal to a slot number
    assign step_strobe = (count[music_pkg::STEP_W-1:2] == '0);

    // Position must not wrap within a run
    a_count_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        count != '0
    );

endmodule

/* src/voice_sequencer.sv */
`timescale 1ns/1ps

module voice_sequencer (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [1:0]                                            fast_start,
    input  logic [music_pkg::COUNT_W-1:0]                         count,
    input  music_pkg::voice_e                                     slot,
    input  logic                                                  step_strobe,
    input  logic [1:0]                                            cur_dur,
    output music_pkg::score_idx_t [music_pkg::NUM_VIOLINS-1:0]    violin_idx
);

    typedef enum logic [1:0] {
        SEQ_LOAD,
        SEQ_PLAY,
        SEQ_ADVANCE   // followers still owe their loop jump
    } seq_state_e;

    seq_state_e                                           state;
    logic [2:0]                                           dur_mask;
    logic                                                 beat_free;
    logic [music_pkg::NUM_VIOLINS-1:0]                    step_now;
    logic                                                 jump_lead;
    logic [music_pkg::NUM_VIOLINS-2:0]                    loop_pending;
    logic [music_pkg::NUM_VIOLINS-2:0]                    pending_next;
    music_pkg::score_idx_t [music_pkg::NUM_VIOLINS-1:0]   next_idx;

    always_comb begin
        case (cur_dur)
            2'd0:    dur_mask = 3'b000;
            2'd1:    dur_mask = 3'b001;
            2'd2:    dur_mask = 3'b111;
            default: dur_mask = 3'b011;
        endcase
    end

    assign beat_free = (count[music_pkg::BEAT_LSB +: music_pkg::BEAT_W] & dur_mask) == '0;

    always_comb begin
        for (int n = 0; n < music_pkg::NUM_VIOLINS; n++) begin
            step_now[n] = step_strobe && beat_free &&
                          (slot == music_pkg::voice_e'(2'(n + 1)));
        end
    end

    always_comb begin
        jump_lead = step_now[0] && (violin_idx[0] == music_pkg::LOOP_END);
        for (int n = 0; n < music_pkg::NUM_VIOLINS; n++) begin
            next_idx[n] = violin_idx[n] + 1'b1;
        end
        if (jump_lead) begin
            next_idx[0] = music_pkg::LOOP_TARGET;
        end
        for (int n = 1; n < music_pkg::NUM_VIOLINS; n++) begin
            if (state == SEQ_ADVANCE && loop_pending[n-1]) begin
                next_idx[n] = music_pkg::LOOP_TARGET -
                              music_pkg::LOOP_SPACING * music_pkg::score_idx_t'(n);
            end
        end
        // Each follower clears its flag on its own next step
        pending_next = jump_lead ? '1 : (loop_pending & ~step_now[music_pkg::NUM_VIOLINS-1:1]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= SEQ_LOAD;
            violin_idx   <= '0;
            loop_pending <= '0;
        end else begin
            case (state)
                SEQ_LOAD: begin
                    for (int n = 0; n < music_pkg::NUM_VIOLINS; n++) begin
                        violin_idx[n] <= music_pkg::VIOLIN_START -
                            music_pkg::VIOLIN_STAGGER * music_pkg::score_idx_t'(n + 1) +
                            music_pkg::FAST_STEP * music_pkg::score_idx_t'(fast_start);
                    end
                    state <= SEQ_PLAY;
                end
                default: begin
                    for (int n = 0; n < music_pkg::NUM_VIOLINS; n++) begin
                        if (step_now[n]) begin
                            violin_idx[n] <= next_idx[n];
                        end
                    end
                    loop_pending <= pending_next;
                    state        <= (pending_next != '0) ? SEQ_ADVANCE : SEQ_PLAY;
                end
            endcase
        end
    end

    // Load happens once per reset
    a_no_reload: assert property (
        @(posedge clk) disable iff (!rst_n)
        state != SEQ_LOAD |=> state != SEQ_LOAD
    );

endmodule

/* src/score_rom.sv */
`timescale 1ns/1ps

module score_rom (
    input  logic [music_pkg::COUNT_W-1:0]                         count,
    input  music_pkg::voice_e                                     slot,
    input  music_pkg::score_idx_t [music_pkg::NUM_VIOLINS-1:0]    violin_idx,
    output logic [1:0]                                            cur_dur,
    output audio_pkg::voice_tick_t                                tick
);

    // Cello bass line, one note per sixteen crotchets
    function automatic audio_pkg::divider_t cello_div(input logic [2:0] idx);
        case (idx)
            3'd0:    cello_div = 11'd949;
            3'd1:    cello_div = 11'd1270;
            3'd2:    cello_div = 11'd1130;
            3'd3:    cello_div = 11'd1512;
            3'd4:    cello_div = 11'd1426;
            3'd5:    cello_div = 11'd1907;
            3'd6:    cello_div = 11'd1426;
            default: cello_div = 11'd1270;
        endcase
    endfunction

    function automatic audio_pkg::divider_t pitch_div(input logic [4:0] pitch);
        case (pitch)
            5'd1:    pitch_div = 11'd568;
            5'd2:    pitch_div = 11'd506;
            5'd3:    pitch_div = 11'd477;
            5'd4:    pitch_div = 11'd425;
            5'd5:    pitch_div = 11'd379;
            5'd6:    pitch_div = 11'd357;
            5'd7:    pitch_div = 11'd318;
            5'd8:    pitch_div = 11'd283;
            5'd9:    pitch_div = 11'd252;
            5'd10:   pitch_div = 11'd238;
            5'd11:   pitch_div = 11'd212;
            5'd12:   pitch_div = 11'd189;
            5'd13:   pitch_div = 11'd178;
            5'd14:   pitch_div = 11'd158;
            5'd15:   pitch_div = 11'd141;
            5'd16:   pitch_div = 11'd125;
            5'd17:   pitch_div = 11'd118;
            default: pitch_div = '0;   // rest or unused
        endcase
    endfunction

    // About 7.5 + 7.5 sin(2 pi x / 16), built from a quarter wave
    function automatic logic [3:0] vibrato_sine(input logic [3:0] phase);
        logic [1:0] quarter;
        logic [2:0] half;
        quarter = phase[2] ? ~phase[1:0] : phase[1:0];
        case (quarter)
            2'd0:    half = 3'd1;
            2'd1:    half = 3'd3;
            2'd2:    half = 3'd6;
            default: half = 3'd7;
        endcase
        vibrato_sine = phase[3] ? {1'b0, 3'd7 - half} : {1'b1, half};
    endfunction

    music_pkg::score_idx_t   cur_idx;
    music_pkg::note_code_t   cur_note;
    audio_pkg::divider_t     cello_pitch;
    logic [3:0]              vibrato;

    always_comb begin
        case (slot)
            music_pkg::VOICE_VIOLIN_2: cur_idx = violin_idx[1];
            music_pkg::VOICE_VIOLIN_3: cur_idx = violin_idx[2];
            default:                   cur_idx = violin_idx[0];
        endcase
    end

    assign cur_note = music_pkg::VIOLIN_SCORE[cur_idx];

    assign vibrato     = vibrato_sine(count[music_pkg::CROTCHET_LSB +: 4]);
    assign cello_pitch = cello_div(count[music_pkg::COUNT_W-1 -: 3]) + {7'd0, vibrato};

    always_comb begin
        tick.voice = slot;
        if (slot == music_pkg::VOICE_CELLO) begin
            cur_dur      = 2'd0;
            // Cello drops out for the closing passage
            tick.divider = (violin_idx[0] >= music_pkg::CELLO_REST_IDX) ? '0 : cello_pitch;
        end else begin
            cur_dur      = cur_note.dur;
            tick.divider = pitch_div(cur_note.pitch);
        end
    end

endmodule

/* src/tone_mixer.sv */
`timescale 1ns/1ps

module tone_mixer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [music_pkg::COUNT_W-1:0]    count,
    input  audio_pkg::voice_tick_t           tick,
    output audio_pkg::sample_t               level
);

    audio_pkg::divider_t                  phase [music_pkg::NUM_VOICES];
    logic [music_pkg::NUM_VOICES-1:0]     square;
    audio_pkg::divider_t                  phase_next;
    audio_pkg::sample_t                   mix;

    assign phase_next = phase[tick.voice] + 1'b1;

    always_comb begin
        mix = square[0] ? audio_pkg::CELLO_WEIGHT : '0;
        for (int v = 1; v < music_pkg::NUM_VOICES; v++) begin
            if (square[v]) begin
                mix = mix + audio_pkg::VIOLIN_WEIGHT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int v = 0; v < music_pkg::NUM_VOICES; v++) begin
                phase[v] <= '0;
            end
            square <= '0;
            level  <= '0;
        end else begin
            // Only the voice owning this slot moves
            if (tick.divider == '0) begin
                phase[tick.voice]  <= '0;
                square[tick.voice] <= 1'b0;
            end else if (phase_next >= tick.divider) begin
                phase[tick.voice]  <= '0;
                square[tick.voice] <= ~square[tick.voice];
            end else begin
                phase[tick.voice] <= phase_next;
            end

            if (count[audio_pkg::FRAME_W-1:0] == '1) begin
                level <= mix;   // held for the whole next frame
            end
        end
    end

endmodule

/* src/pwm_dac.sv */
`timescale 1ns/1ps

module pwm_dac (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [music_pkg::COUNT_W-1:0]    count,
    input  audio_pkg::sample_t               level,
    output logic                             pwm
);

    logic [audio_pkg::FRAME_W-1:0]   frame_pos;
    audio_pkg::sample_t              duty;
    audio_pkg::sample_t              duty_now;

    assign frame_pos = count[audio_pkg::FRAME_W-1:0];

    // Frame start compares against the incoming level
    assign duty_now = (frame_pos == '0) ? level : duty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty <= '0;
            pwm  <= 1'b0;
        end else begin
            if (frame_pos == '0) begin
                duty <= level;
            end
            pwm <= (frame_pos < duty_now);
        end
    end

endmodule

/* src/pwm_music.sv */
`timescale 1ns/1ps

module pwm_music (
    input  logic                                                           clk,
    input  logic                                                           rst_n,
    input  logic [1:0]                                                     fast_start,
    output logic                                                           pwm,
    output logic [music_pkg::LOW_COUNT_W-1:0]                              low_count,
    output logic [music_pkg::COUNT_W-music_pkg::CROTCHET_LSB-1:0]          crotchet,
    output audio_pkg::sample_t                                             level
);

    logic [music_pkg::COUNT_W-1:0]                        count;
    music_pkg::voice_e                                    slot;
    logic                                                 step_strobe;
    logic [1:0]                                           cur_dur;
    music_pkg::score_idx_t [music_pkg::NUM_VIOLINS-1:0]   violin_idx;
    audio_pkg::voice_tick_t                               tick;

    beat_counter beat_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .count       (count),
        .slot        (slot),
        .step_strobe (step_strobe)
    );

    voice_sequencer voice_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fast_start  (fast_start),
        .count       (count),
        .slot        (slot),
        .step_strobe (step_strobe),
        .cur_dur     (cur_dur),
        .violin_idx  (violin_idx)
    );

    score_rom score_rom_i (
        .count      (count),
        .slot       (slot),
        .violin_idx (violin_idx),
        .cur_dur    (cur_dur),
        .tick       (tick)
    );

    tone_mixer tone_mixer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .count (count),
        .tick  (tick),
        .level (level)
    );

    pwm_dac pwm_dac_i (
        .clk   (clk),
        .rst_n (rst_n),
        .count (count),
        .level (level),
        .pwm   (pwm)
    );

    assign low_count = count[music_pkg::LOW_COUNT_W-1:0];
    assign crotchet  = count[music_pkg::COUNT_W-1:music_pkg::CROTCHET_LSB];   // display field

endmodule

/* testbench/tb_pwm_music.sv */
`timescale 1ns/1ps

module tb_pwm_music;

    localparam int     CLK_PERIOD     = 100;
    localparam int     RESET_CYCLES   = 3;
    localparam int     FRAME_CYCLES   = 256;
    localparam longint COUNTER_CYCLES = 140000;   // past the first crotchet change
    localparam longint PWM_FRAMES     = 20;
    localparam longint RANGE_FRAMES   = 40;
    localparam longint QUIET_LIMIT    = 20000;
    localparam longint TEMPO_FRAMES   = 1024;     // two crotchets
    localparam longint WATCHDOG_CYCLES = COUNTER_CYCLES + (PWM_FRAMES + 1) * FRAME_CYCLES +
        4 * (RANGE_FRAMES * FRAME_CYCLES + 2 * RESET_CYCLES) + QUIET_LIMIT +
        (TEMPO_FRAMES + 1) * FRAME_CYCLES + 10 * RESET_CYCLES + 10000;

    logic               clk = 1'b0;
    logic               rst_n;
    logic [1:0]         fast_start;
    logic               pwm;
    logic [9:0]         low_count;
    logic [6:0]         crotchet;
    logic [7:0]         level;
    logic [23:0]        model_count;
    integer             seed;

    pwm_music dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fast_start (fast_start),
        .pwm        (pwm),
        .low_count  (low_count),
        .crotchet   (crotchet),
        .level      (level)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Reference position, reloads to 1 in reset
    always @(posedge clk) begin
        model_count <= !rst_n ? 24'd1 : model_count + 24'd1;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic flag_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "first error");
    endtask

    task automatic apply_reset(input logic [1:0] fs);
        @(posedge clk);
        rst_n      <= 1'b0;
        fast_start <= fs;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_frame_start;
        do @(negedge clk); while (low_count[7:0] != 8'd0);
    endtask

    // Any sum of one cello weight and up to three violin weights
    function automatic bit is_weight_sum(input logic [7:0] value);
        bit found;
        found = 1'b0;
        for (int c = 0; c < 2; c++) begin
            for (int n = 0; n < 4; n++) begin
                if (value == 8'(c * audio_pkg::CELLO_WEIGHT + n * audio_pkg::VIOLIN_WEIGHT)) begin
                    found = 1'b1;
                end
            end
        end
        return found;
    endfunction

    task automatic test_counter;
        @(negedge clk);
        assert (low_count == 10'd1)
            else flag_mismatch($sformatf("low_count %0d after reset", low_count));
        for (longint i = 1; i < COUNTER_CYCLES; i++) begin
            @(negedge clk);
            assert (low_count == model_count[9:0])   // wraps at 10 bits
                else flag_mismatch($sformatf("low_count %0d, expected %0d",
                                             low_count, model_count[9:0]));
            assert (crotchet == model_count[23:17])
                else flag_mismatch($sformatf("crotchet %0d, expected %0d",
                                             crotchet, model_count[23:17]));
        end
    endtask

    task automatic test_pwm_width;
        logic [7:0] expected;
        int         high_count;
        wait_frame_start();
        for (int f = 0; f < PWM_FRAMES; f++) begin
            expected   = level;
            high_count = 0;
            repeat (FRAME_CYCLES) begin
                @(negedge clk);
                high_count += pwm;
            end
            assert (high_count == int'(expected))
                else flag_mismatch($sformatf("pwm high %0d cycles, level was %0d",
                                             high_count, expected));
        end
    endtask

    task automatic test_level_range;
        logic [1:0] order [4];
        logic [1:0] tmp;
        int         pick;
        logic [7:0] prev_level;
        bit         prev_wrap;
        for (int i = 0; i < 4; i++) begin
            order[i] = 2'(i);
        end
        for (int i = 3; i > 0; i--) begin
            pick       = $unsigned($random(seed)) % (i + 1);
            tmp        = order[i];
            order[i]   = order[pick];
            order[pick] = tmp;
        end
        for (int k = 0; k < 4; k++) begin
            apply_reset(order[k]);
            @(negedge clk);
            assert (level == 8'd0) else flag_mismatch($sformatf("level %0d after reset", level));
            prev_level = level;
            prev_wrap  = (low_count[7:0] == 8'hff);
            repeat (RANGE_FRAMES * FRAME_CYCLES) begin
                @(negedge clk);
                if (!prev_wrap) begin
                    assert (level == prev_level)
                        else flag_mismatch($sformatf("level moved %0d to %0d mid frame",
                                                     prev_level, level));
                end
                assert (is_weight_sum(level))
                    else flag_mismatch($sformatf("level %0d is no weight sum, fast_start %0d",
                                                 level, order[k]));
                prev_level = level;
                prev_wrap  = (low_count[7:0] == 8'hff);
            end
        end
    endtask

    task automatic test_quiet_reset;
        bit     sounding;
        longint waited;
        @(posedge clk);
        rst_n      <= 1'b0;
        fast_start <= 2'd0;
        for (int i = 1; i <= RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            assert (pwm == 1'b0) else flag_mismatch("pwm high during reset");
        end
        sounding = 1'b0;
        waited   = 0;
        while (!sounding) begin
            if (low_count[7:0] == 8'd0 && level != 8'd0) begin
                sounding = 1'b1;
            end else begin
                assert (pwm == 1'b0) else flag_mismatch("pwm high before the first sounding frame");
                waited++;
                if (waited > QUIET_LIMIT) begin
                    abort_run("No frame with a nonzero level appeared after reset");
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic test_tempo;
        logic [255:0] seen;
        seen = '0;
        wait_frame_start();
        for (longint f = 0; f < TEMPO_FRAMES; f++) begin
            seen[level] = 1'b1;
            repeat (FRAME_CYCLES) @(negedge clk);
        end
        assert ($countones(seen) > 1)
            else abort_run("The level kept a single value over two crotchets, so no voice moved");
    endtask

    initial begin
        seed        = 48;
        rst_n      <= 1'b0;
        fast_start <= 2'd0;
        apply_reset(2'd0);
        test_counter();
        test_pwm_width();
        test_level_range();
        test_quiet_reset();
        test_tempo();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* compile.f */
src/music_pkg.sv
src/audio_pkg.sv
src/beat_counter.sv
src/voice_sequencer.sv
src/score_rom.sv
src/tone_mixer.sv
src/pwm_dac.sv
src/pwm_music.sv
testbench/tb_pwm_music.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pwm_music -f compile.f > build.log 2>&1 &&
    ./obj_dir/Vtb_pwm_music > sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log 2>/dev/null && echo "Simulation passed" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }
